//--- include/ooo_cfg.svh
// Configuration constants for the register scoreboard slice of the out-of-order core
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Number of architectural registers, register 0 reads as always valid
`define OOO_NREGS 64

// Width of a register index inside an instruction word
`define OOO_REG_W 6

// Reorder buffer depth and the width of a tag into it
`define OOO_ROB_ENTRIES 8
`define OOO_TAG_W 3

`endif

//--- hw/ooo_pkg.sv
// Shared types of the core slice: opcodes, decoded instructions, reorder entries, commits
`include "ooo_cfg.svh"

package ooo_pkg;

	// ====================
	// Opcodes
	// ====================

	// The opcode sits in bits 31:28 of an instruction word
	// Only OP_ALU and OP_LOAD write a register
	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_ALU    = 4'd1,
		OP_LOAD   = 4'd2,
		OP_STORE  = 4'd3,
		OP_BRANCH = 4'd4
	} opcode_e;

	// ====================
	// Pipeline records
	// ====================

	// One decoded slot, 12 bits
	typedef struct packed {
		logic                  valid;
		opcode_e               op;
		logic                  rfwr;
		logic [`OOO_REG_W-1:0] rt;
	} decoded_t;

	// One reorder buffer entry, 9 bits
	// Busy marks an allocated slot, done marks a finished instruction
	typedef struct packed {
		logic                  busy;
		logic                  done;
		logic                  rfwr;
		logic [`OOO_REG_W-1:0] rt;
	} rob_entry_t;

	// One commit port, 11 bits
	typedef struct packed {
		logic                  valid;
		logic [`OOO_TAG_W-1:0] tag;
		logic                  wr;
		logic [`OOO_REG_W-1:0] tgt;
	} commit_t;

endpackage

//--- hw/insn_decode.sv
// Two-slot instruction decoder that extracts opcode, register write flag and target
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module insn_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              dispatch0_valid,
	input  logic [31:0]       dispatch0_insn,
	input  logic              dispatch1_valid,
	input  logic [31:0]       dispatch1_insn,
	output ooo_pkg::decoded_t dec0,
	output ooo_pkg::decoded_t dec1
);

	// Same decode for both slots
	// Unknown opcode values collapse to a NOP that writes nothing
	function automatic ooo_pkg::decoded_t decode_word(input logic vld, input logic [31:0] insn);
		ooo_pkg::decoded_t d;
		d.valid = vld;
		case (insn[31:28])
			ooo_pkg::OP_ALU:    d.op = ooo_pkg::OP_ALU;
			ooo_pkg::OP_LOAD:   d.op = ooo_pkg::OP_LOAD;
			ooo_pkg::OP_STORE:  d.op = ooo_pkg::OP_STORE;
			ooo_pkg::OP_BRANCH: d.op = ooo_pkg::OP_BRANCH;
			default:            d.op = ooo_pkg::OP_NOP;
		endcase
		d.rfwr = (d.op == ooo_pkg::OP_ALU) || (d.op == ooo_pkg::OP_LOAD);
		// Target register follows the opcode field
		d.rt = insn[27:22];
		return d;
	endfunction

	assign dec0 = decode_word(dispatch0_valid, dispatch0_insn);
	assign dec1 = decode_word(dispatch1_valid, dispatch1_insn);

	// Slot 1 is always the younger of a pair, so it never arrives alone
	a_slot1_needs_slot0: assert property (@(posedge clk) disable iff (rst)
		dispatch1_valid |-> dispatch0_valid);

endmodule

//--- hw/reorder_buffer.sv
// Eight-entry reorder buffer that allocates tags, tracks completion, commits two and flushes
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reorder_buffer (
	input  logic                                            clk,
	input  logic                                            rst,
	input  ooo_pkg::decoded_t                               dec0,
	input  ooo_pkg::decoded_t                               dec1,
	input  logic                                            complete_valid,
	input  logic [`OOO_TAG_W-1:0]                           complete_tag,
	input  logic                                            branch_miss,
	input  logic [`OOO_TAG_W-1:0]                           branch_tag,
	output logic                                            dispatch_ready,
	output ooo_pkg::rob_entry_t [`OOO_ROB_ENTRIES-1:0]      entries,
	output logic [`OOO_TAG_W-1:0]                           head,
	output logic [`OOO_ROB_ENTRIES-1:0]                     keep,
	output ooo_pkg::commit_t                                commit0,
	output ooo_pkg::commit_t                                commit1
);

	localparam int TAG_W = `OOO_TAG_W;
	localparam int CNT_W = `OOO_TAG_W + 1;

	// Tail is the next tag handed out, count is the number of busy entries
	logic [TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic [TAG_W-1:0] head1;
	logic [TAG_W-1:0] tail1;
	// Distance of the mispredicted branch from the head
	logic [TAG_W-1:0] miss_age;
	logic             accept0;
	logic             accept1;
	logic [1:0]       n_commit;
	logic [1:0]       n_alloc;

	assign head1 = head + TAG_W'(1);
	assign tail1 = tail + TAG_W'(1);
	assign miss_age = branch_tag - head;

	// ====================
	// Dispatch
	// ====================

	// Two free slots are needed so a pair never has to split
	assign dispatch_ready = (count <= CNT_W'(`OOO_ROB_ENTRIES - 2)) && !branch_miss;
	assign accept0 = dec0.valid && dispatch_ready;
	assign accept1 = dec1.valid && accept0;
	assign n_alloc = 2'(accept0) + 2'(accept1);

	// ====================
	// Flush mask
	// ====================

	// An entry survives unless a miss is active and it sits younger than the branch
	// Age is measured from the head, the wrap of the tag does the modulo
	always_comb begin
		for (int i = 0; i < `OOO_ROB_ENTRIES; i++) begin
			keep[i] = entries[i].busy;
			if (branch_miss && ((TAG_W'(i) - head) > miss_age))
				keep[i] = 1'b0;
		end
	end

	// ====================
	// Commit select
	// ====================

	// Oldest entry first, the second port only follows a valid first one
	// Nothing commits while a miss is being repaired
	always_comb begin
		commit0.valid = entries[head].busy && entries[head].done && !branch_miss;
		commit0.tag = head;
		commit0.wr = entries[head].rfwr;
		commit0.tgt = entries[head].rt;
		commit1.valid = commit0.valid && entries[head1].busy && entries[head1].done;
		commit1.tag = head1;
		commit1.wr = entries[head1].rfwr;
		commit1.tgt = entries[head1].rt;
	end

	assign n_commit = 2'(commit0.valid) + 2'(commit1.valid);

	// ====================
	// State update
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < `OOO_ROB_ENTRIES; i++) begin
				entries[i].busy <= 1'b0;
				entries[i].done <= 1'b0;
			end
		end else begin
			if (complete_valid)
				entries[complete_tag].done <= 1'b1;
			if (branch_miss) begin
				// Dropping younger entries also cancels a completion to them this cycle
				for (int i = 0; i < `OOO_ROB_ENTRIES; i++) begin
					if (!keep[i]) begin
						entries[i].busy <= 1'b0;
						entries[i].done <= 1'b0;
					end
				end
				tail <= branch_tag + TAG_W'(1);
				count <= CNT_W'(miss_age) + CNT_W'(1);
			end else begin
				if (commit0.valid)
					entries[head].busy <= 1'b0;
				if (commit1.valid)
					entries[head1].busy <= 1'b0;
				// Non-writers have nothing left to do, so they are done on entry
				if (accept0)
					entries[tail] <= '{busy: 1'b1, done: !dec0.rfwr, rfwr: dec0.rfwr, rt: dec0.rt};
				if (accept1)
					entries[tail1] <= '{busy: 1'b1, done: !dec1.rfwr, rfwr: dec1.rfwr, rt: dec1.rt};
				head <= head + TAG_W'(n_commit);
				tail <= tail + TAG_W'(n_alloc);
				count <= count - CNT_W'(n_commit) + CNT_W'(n_alloc);
			end
		end
	end

	// A completion names an instruction that is still in flight
	a_complete_busy: assert property (@(posedge clk) disable iff (rst)
		complete_valid |-> entries[complete_tag].busy);

	// Allocation stops early enough that the buffer never overfills
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(`OOO_ROB_ENTRIES));

endmodule

//--- hw/reg_source_map.sv
// Finds the youngest in-flight writer of every register and the targets that survive a flush
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reg_source_map (
	input  ooo_pkg::rob_entry_t [`OOO_ROB_ENTRIES-1:0]  entries,
	input  logic [`OOO_TAG_W-1:0]                       head,
	input  logic [`OOO_ROB_ENTRIES-1:0]                 keep,
	output logic [`OOO_NREGS-1:0][`OOO_TAG_W-1:0]       reg_src,
	output logic [`OOO_NREGS-1:0]                       live_target
);

	localparam int TAG_W = `OOO_TAG_W;

	// Slot being visited on the current step of the walk
	logic [TAG_W-1:0] idx;

	// ====================
	// Program-order walk
	// ====================

	// Starting at the head means later matches are younger
	// The last writer seen for a register therefore wins
	// Registers with no writer keep tag 0, which no commit can match since
	// a committing entry is itself a writer of its target
	always_comb begin
		reg_src = '0;
		live_target = '0;
		idx = head;
		for (int k = 0; k < `OOO_ROB_ENTRIES; k++) begin
			idx = head + TAG_W'(k);
			if (entries[idx].busy && entries[idx].rfwr)
				reg_src[entries[idx].rt] = idx;
			// Only writers that outlive this cycle's flush hold their register invalid
			if (keep[idx] && entries[idx].rfwr)
				live_target[entries[idx].rt] = 1'b1;
		end
	end

endmodule

//--- hw/regfile_valid.sv
// Register readiness scoreboard with decode clear, commit set and branch-miss repair
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module regfile_valid (
	input  logic                                  clk,
	input  logic                                  rst,
	input  ooo_pkg::decoded_t                     dec0,
	input  ooo_pkg::decoded_t                     dec1,
	input  ooo_pkg::commit_t                      commit0,
	input  ooo_pkg::commit_t                      commit1,
	input  logic                                  branch_miss,
	input  logic [`OOO_NREGS-1:0][`OOO_TAG_W-1:0] reg_src,
	input  logic [`OOO_NREGS-1:0]                 live_target,
	output logic [`OOO_NREGS-1:0]                 regfile_valid
);

	logic [`OOO_NREGS-1:0] next_valid;

	// ====================
	// Next-state vector
	// ====================

	// A commit only frees its target if no younger writer has claimed it since
	// Commits and a miss never share a cycle, the buffer holds commits off then
	always_comb begin
		next_valid = regfile_valid;
		if (branch_miss) begin
			for (int r = 0; r < `OOO_NREGS; r++) begin
				if (!live_target[r])
					next_valid[r] = 1'b1;
			end
		end
		if (commit0.valid && commit0.wr && (reg_src[commit0.tgt] == commit0.tag))
			next_valid[commit0.tgt] = 1'b1;
		if (commit1.valid && commit1.wr && (reg_src[commit1.tgt] == commit1.tag))
			next_valid[commit1.tgt] = 1'b1;
	end

	// ====================
	// Register
	// ====================

	// Decode clears land last so a new writer beats a commit of the old one
	// No dispatch is taken during a miss, so clears are held off then too
	always_ff @(posedge clk) begin
		if (rst) begin
			regfile_valid <= '1;
		end else begin
			regfile_valid <= next_valid;
			if (dec0.valid && dec0.rfwr && !branch_miss)
				regfile_valid[dec0.rt] <= 1'b0;
			if (dec0.valid && dec1.valid && dec1.rfwr && !branch_miss)
				regfile_valid[dec1.rt] <= 1'b0;
			regfile_valid[0] <= 1'b1;
		end
	end

	a_reg0_valid: assert property (@(posedge clk) disable iff (rst)
		regfile_valid[0]);

	// The buffer hands out two distinct slots per cycle
	a_commit_tags_differ: assert property (@(posedge clk) disable iff (rst)
		(commit0.valid && commit1.valid) |-> (commit0.tag != commit1.tag));

endmodule

//--- hw/ooo_core_top.sv
// Top of the scoreboard slice joining decode, reorder buffer, source map and valid bits
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_core_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dispatch0_valid,
	input  logic [31:0]             dispatch0_insn,
	input  logic                    dispatch1_valid,
	input  logic [31:0]             dispatch1_insn,
	output logic                    dispatch_ready,
	input  logic                    complete_valid,
	input  logic [`OOO_TAG_W-1:0]   complete_tag,
	input  logic                    branch_miss,
	input  logic [`OOO_TAG_W-1:0]   branch_tag,
	output ooo_pkg::commit_t        commit0,
	output ooo_pkg::commit_t        commit1,
	output logic [`OOO_NREGS-1:0]   regfile_valid
);

	ooo_pkg::decoded_t                             dec0;
	ooo_pkg::decoded_t                             dec1;
	ooo_pkg::rob_entry_t [`OOO_ROB_ENTRIES-1:0]    entries;
	logic [`OOO_TAG_W-1:0]                         head;
	logic [`OOO_ROB_ENTRIES-1:0]                   keep;
	logic [`OOO_NREGS-1:0][`OOO_TAG_W-1:0]         reg_src;
	logic [`OOO_NREGS-1:0]                         live_target;

	insn_decode i_insn_decode (
		.clk(clk), .rst(rst),
		.dispatch0_valid(dispatch0_valid), .dispatch0_insn(dispatch0_insn),
		.dispatch1_valid(dispatch1_valid), .dispatch1_insn(dispatch1_insn),
		.dec0(dec0), .dec1(dec1)
	);

	reorder_buffer i_reorder_buffer (
		.clk(clk), .rst(rst), .dec0(dec0), .dec1(dec1),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.branch_miss(branch_miss), .branch_tag(branch_tag),
		.dispatch_ready(dispatch_ready), .entries(entries), .head(head), .keep(keep),
		.commit0(commit0), .commit1(commit1)
	);

	// Source map reads the buffer as it stands before this cycle's commits
	reg_source_map i_reg_source_map (
		.entries(entries), .head(head), .keep(keep),
		.reg_src(reg_src), .live_target(live_target)
	);

	regfile_valid i_regfile_valid (
		.clk(clk), .rst(rst), .dec0(dec0), .dec1(dec1),
		.commit0(commit0), .commit1(commit1), .branch_miss(branch_miss),
		.reg_src(reg_src), .live_target(live_target), .regfile_valid(regfile_valid)
	);

endmodule

//--- tb/tb_clock.sv
// Testbench clock and reset source with an 8 ns period and reset held for four cycles
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset drops a nanosecond after the fourth rising edge
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

//--- tb/tb_ooo_core_top.sv
// Testbench for the core slice with random dispatch, completion and branch misses against a model
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module tb_ooo_core_top;

	localparam int TAG_W = `OOO_TAG_W;

	// One in-flight instruction as the model sees it
	typedef struct packed {
		logic [`OOO_TAG_W-1:0] tag;
		logic                  wr;
		logic [`OOO_REG_W-1:0] tgt;
		logic                  done;
	} model_entry_t;

	logic clk;
	logic rst;
	logic dispatch0_valid;
	logic [31:0] dispatch0_insn;
	logic dispatch1_valid;
	logic [31:0] dispatch1_insn;
	logic dispatch_ready;
	logic complete_valid;
	logic [`OOO_TAG_W-1:0] complete_tag;
	logic branch_miss;
	logic [`OOO_TAG_W-1:0] branch_tag;
	ooo_pkg::commit_t commit0;
	ooo_pkg::commit_t commit1;
	logic [`OOO_NREGS-1:0] regfile_valid;

	// Oldest entry sits at the front, the tail is the next tag to hand out
	model_entry_t model_q[$];
	logic [`OOO_TAG_W-1:0] model_tail;
	logic [31:0] rng_state;

	tb_clock i_tb_clock (.clk(clk), .rst(rst));

	ooo_core_top i_ooo_core_top (
		.clk(clk), .rst(rst),
		.dispatch0_valid(dispatch0_valid), .dispatch0_insn(dispatch0_insn),
		.dispatch1_valid(dispatch1_valid), .dispatch1_insn(dispatch1_insn),
		.dispatch_ready(dispatch_ready),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.branch_miss(branch_miss), .branch_tag(branch_tag),
		.commit0(commit0), .commit1(commit1), .regfile_valid(regfile_valid)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] rand_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Upper bits of the generator are the well mixed ones
	function automatic int rand_below(input int n);
		return int'((rand_next() >> 8) % 32'(n));
	endfunction

	// Opcode in bits 31:28, ALU (1) and LOAD (2) write the register in bits 27:22
	function automatic model_entry_t decode_entry(input logic [31:0] insn,
			input logic [`OOO_TAG_W-1:0] tag);
		model_entry_t e;
		e.tag = tag;
		e.wr = (insn[31:28] == 4'd1) || (insn[31:28] == 4'd2);
		e.tgt = insn[27:22];
		e.done = !e.wr;
		return e;
	endfunction

	// A register is ready unless some in-flight writer still targets it
	function automatic logic [`OOO_NREGS-1:0] expected_valid();
		logic [`OOO_NREGS-1:0] v;
		v = '1;
		foreach (model_q[i])
			if (model_q[i].wr)
				v[model_q[i].tgt] = 1'b0;
		v[0] = 1'b1;
		return v;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_commit(input string name, input ooo_pkg::commit_t got,
			input ooo_pkg::commit_t exp);
		if ((got.valid !== exp.valid) || (exp.valid && (got !== exp)))
			stop_on_error($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
	endtask

	task automatic check_valid(input logic [`OOO_NREGS-1:0] got, input logic [`OOO_NREGS-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED t=%0t regfile_valid got=%h exp=%h",
				$time, got, exp));
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED t=%0t dispatch_ready got=%b exp=%b",
				$time, got, exp));
	endtask

	// ====================
	// One cycle
	// ====================

	// Entered 1 ns after a rising edge, leaves 1 ns after the next one
	task automatic run_cycle(input bit allow_new);
		ooo_pkg::commit_t exp0;
		ooo_pkg::commit_t exp1;
		int pending[$];
		int miss_idx;
		int pick;
		logic model_ready;
		check_valid(regfile_valid, expected_valid());
		dispatch0_valid = 1'b0;
		dispatch1_valid = 1'b0;
		complete_valid = 1'b0;
		branch_miss = 1'b0;
		miss_idx = -1;
		pick = -1;
		// Misses stay rare so the buffer gets to fill and drain between them
		if (allow_new && (model_q.size() != 0) && (rand_below(40) == 0)) begin
			miss_idx = rand_below(model_q.size());
			branch_miss = 1'b1;
			branch_tag = model_q[miss_idx].tag;
		end
		foreach (model_q[i])
			if (!model_q[i].done)
				pending.push_back(i);
		if ((pending.size() != 0) && (rand_below(4) != 0)) begin
			pick = pending[rand_below(pending.size())];
			complete_valid = 1'b1;
			complete_tag = model_q[pick].tag;
		end
		model_ready = (model_q.size() <= `OOO_ROB_ENTRIES - 2) && !branch_miss;
		if (allow_new && model_ready && (rand_below(4) != 0)) begin
			dispatch0_valid = 1'b1;
			dispatch0_insn = rand_next();
			if (rand_below(2) != 0) begin
				dispatch1_valid = 1'b1;
				dispatch1_insn = rand_next();
			end
		end
		#1;
		check_ready(dispatch_ready, model_ready);
		// The two oldest entries retire together only when both are done
		exp0 = '0;
		exp1 = '0;
		if ((model_q.size() > 0) && model_q[0].done && !branch_miss)
			exp0 = '{valid: 1'b1, tag: model_q[0].tag, wr: model_q[0].wr, tgt: model_q[0].tgt};
		if (exp0.valid && (model_q.size() > 1) && model_q[1].done)
			exp1 = '{valid: 1'b1, tag: model_q[1].tag, wr: model_q[1].wr, tgt: model_q[1].tgt};
		check_commit("commit0", commit0, exp0);
		check_commit("commit1", commit1, exp1);
		if (pick >= 0)
			model_q[pick].done = 1'b1;
		if (branch_miss) begin
			while (model_q.size() > miss_idx + 1)
				model_q.delete(model_q.size() - 1);
			model_tail = branch_tag + TAG_W'(1);
		end else begin
			if (exp0.valid)
				model_q.delete(0);
			if (exp1.valid)
				model_q.delete(0);
			if (dispatch0_valid) begin
				model_q.push_back(decode_entry(dispatch0_insn, model_tail));
				model_tail = model_tail + TAG_W'(1);
			end
			if (dispatch1_valid) begin
				model_q.push_back(decode_entry(dispatch1_insn, model_tail));
				model_tail = model_tail + TAG_W'(1);
			end
		end
		@(posedge clk);
		#1;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int waited;
		dispatch0_valid = 1'b0;
		dispatch0_insn = '0;
		dispatch1_valid = 1'b0;
		dispatch1_insn = '0;
		complete_valid = 1'b0;
		complete_tag = '0;
		branch_miss = 1'b0;
		branch_tag = '0;
		rng_state = 32'h211b7937;
		model_tail = '0;
		waited = 0;
		// Reset is first looked at on a clock edge, once the clock source has set it
		do begin
			@(posedge clk);
			waited++;
			if (waited > 20)
				stop_on_error("reset was never released");
		end while (rst);
		#1;
		// Idle state straight out of reset
		check_valid(regfile_valid, '1);
		check_commit("commit0", commit0, '0);
		check_commit("commit1", commit1, '0);
		check_ready(dispatch_ready, 1'b1);
		for (int cyc = 0; cyc < 3000; cyc++)
			run_cycle(1'b1);
		// No new work, completions keep coming until every entry has retired
		waited = 0;
		while (model_q.size() != 0) begin
			run_cycle(1'b0);
			waited++;
			if (waited > 200)
				stop_on_error("reorder buffer did not drain after the random phase");
		end
		check_valid(regfile_valid, '1);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+include
hw/ooo_pkg.sv
hw/insn_decode.sv
hw/reorder_buffer.sv
hw/reg_source_map.sv
hw/regfile_valid.sv
hw/ooo_core_top.sv
tb/tb_clock.sv
tb/tb_ooo_core_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only when the pass line is printed
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ooo_core_top -f all.f
sim_out=$(./obj_dir/Vtb_ooo_core_top 2>&1) || true
echo "$sim_out"
if echo "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
